//--- design/fpadd_pkg.sv
package fpadd_pkg;

  typedef logic [63:0] fp64_t;
  // biased exponent plus one overflow bit
  typedef logic [11:0] exp_t;
  // carry, hidden, 52 fraction bits, then guard, round, sticky
  typedef logic [56:0] sig_t;
  typedef logic [1:0]  rnd_mode_t;
  typedef logic [2:0]  flags_t;

  localparam rnd_mode_t RND_TRUNC = 2'd0;
  localparam rnd_mode_t RND_EVEN  = 2'd1;
  localparam rnd_mode_t RND_PLUS  = 2'd2;
  localparam rnd_mode_t RND_MINUS = 2'd3;

  localparam int FLAG_INVALID  = 2;
  localparam int FLAG_OVERFLOW = 1;
  localparam int FLAG_INEXACT  = 0;

  localparam fp64_t QNAN_CANON = 64'h7ff8000000000000;

  typedef struct packed {
    fp64_t     a;
    fp64_t     b;
    logic      sub;
    rnd_mode_t rmode;
  } fpadd_req_t;

  // stage 1 output, operands swapped so big has the larger magnitude
  typedef struct packed {
    logic      big_sign;
    logic      eff_sub;
    rnd_mode_t rmode;
    exp_t      big_exp;
    sig_t      big_sig;
    sig_t      small_sig;
    logic      spec_valid;
    fp64_t     spec_value;
    flags_t    spec_flags;
  } aligned_t;

  typedef struct packed {
    logic      sign;
    rnd_mode_t rmode;
    exp_t      exp;
    sig_t      sig;
    logic      spec_valid;
    fp64_t     spec_value;
    flags_t    spec_flags;
  } sum_t;

  typedef struct packed {
    fp64_t  result;
    flags_t flags;
  } fpadd_resp_t;

endpackage

//--- design/fpadd_lzd_lane.sv
`timescale 1ns/1ps

module fpadd_lzd_lane (
  input  logic [7:0] byte_in,
  output logic       has_one,
  output logic [2:0] lead_pos
);

  assign has_one = |byte_in;

  // scan upward so the highest set bit wins
  always_comb begin
    lead_pos = 3'd0;
    for (int i = 0; i < 8; i++) begin
      if (byte_in[i]) begin
        lead_pos = 3'(i);
      end
    end
  end

endmodule

//--- design/fpadd_align.sv
`timescale 1ns/1ps

module fpadd_align import fpadd_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       in_valid,
  input  fpadd_req_t in_req,
  output logic       al_valid,
  output aligned_t   al
);

  logic [10:0] a_exp;
  logic [10:0] b_exp;
  logic        b_sign;
  logic        eff_sub;
  logic        a_zero;
  logic        b_zero;
  logic        a_inf;
  logic        b_inf;
  logic        a_nan;
  logic        b_nan;
  logic [62:0] a_mag;
  logic [62:0] b_mag;
  logic        a_big;
  logic [62:0] big_mag;
  logic [62:0] small_mag;
  exp_t        big_exp;
  exp_t        small_exp;
  exp_t        exp_diff;
  sig_t        small_pre;
  sig_t        small_shr;
  logic        small_lost;
  aligned_t    al_next;

  assign a_exp = in_req.a[62:52];
  assign b_exp = in_req.b[62:52];

  // effective sign of b after the operation
  assign b_sign  = in_req.b[63] ^ in_req.sub;
  assign eff_sub = in_req.a[63] ^ b_sign;

  assign a_zero = a_exp == 11'd0;
  assign b_zero = b_exp == 11'd0;
  assign a_inf  = (a_exp == 11'h7ff) && (in_req.a[51:0] == 52'd0);
  assign b_inf  = (b_exp == 11'h7ff) && (in_req.b[51:0] == 52'd0);
  assign a_nan  = (a_exp == 11'h7ff) && (in_req.a[51:0] != 52'd0);
  assign b_nan  = (b_exp == 11'h7ff) && (in_req.b[51:0] != 52'd0);

  // denormals flush to zero here
  assign a_mag = a_zero ? 63'd0 : in_req.a[62:0];
  assign b_mag = b_zero ? 63'd0 : in_req.b[62:0];
  assign a_big = a_mag >= b_mag;

  assign big_mag   = a_big ? a_mag : b_mag;
  assign small_mag = a_big ? b_mag : a_mag;
  assign big_exp   = {1'b0, big_mag[62:52]};
  assign small_exp = {1'b0, small_mag[62:52]};
  assign exp_diff  = big_exp - small_exp;

  assign small_pre = {1'b0, small_mag[62:52] != 11'd0, small_mag[51:0], 3'b000};
  assign small_shr = small_pre >> exp_diff;
  // anything shifted past bit 0 lands in sticky; past 55 only sticky is left
  assign small_lost = |(small_pre & ~({57{1'b1}} << exp_diff));

  always_comb begin
    al_next.big_sign   = a_big ? in_req.a[63] : b_sign;
    al_next.eff_sub    = eff_sub;
    al_next.rmode      = in_req.rmode;
    al_next.big_exp    = big_exp;
    al_next.big_sig    = {1'b0, big_mag[62:52] != 11'd0, big_mag[51:0], 3'b000};
    al_next.small_sig  = {small_shr[56:1], small_shr[0] | small_lost};
    al_next.spec_valid = a_nan | b_nan | a_inf | b_inf;
    al_next.spec_flags = '0;
    if (a_nan || b_nan) begin
      al_next.spec_value = QNAN_CANON;
    end else if (a_inf && b_inf && eff_sub) begin
      al_next.spec_value = QNAN_CANON;
      al_next.spec_flags[FLAG_INVALID] = 1'b1;
    end else begin
      al_next.spec_value = {a_inf ? in_req.a[63] : b_sign, 11'h7ff, 52'd0};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      al_valid <= 1'b0;
    end else begin
      al_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    al <= al_next;
  end

endmodule

//--- design/fpadd_significand_add.sv
`timescale 1ns/1ps

module fpadd_significand_add import fpadd_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     al_valid,
  input  aligned_t al,
  output logic     sum_valid,
  output sum_t     sum
);

  sig_t sig_res;
  logic cancel;
  sum_t sum_next;

  // big >= small after the swap, so no negative difference
  assign sig_res = al.eff_sub ? al.big_sig - al.small_sig : al.big_sig + al.small_sig;

  // exact cancellation is +0, or -0 when rounding toward minus
  assign cancel = al.eff_sub && (sig_res == '0);

  always_comb begin
    sum_next.sign       = cancel ? (al.rmode == RND_MINUS) : al.big_sign;
    sum_next.rmode      = al.rmode;
    sum_next.exp        = al.big_exp;
    sum_next.sig        = sig_res;
    sum_next.spec_valid = al.spec_valid;
    sum_next.spec_value = al.spec_value;
    sum_next.spec_flags = al.spec_flags;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= al_valid;
    end
  end

  always_ff @(posedge clk) begin
    sum <= sum_next;
  end

endmodule

//--- design/fpadd_normalize_round.sv
`timescale 1ns/1ps

module fpadd_normalize_round import fpadd_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        sum_valid,
  input  sum_t        sum,
  input  logic [7:0]  lane_has,
  input  logic [23:0] lane_pos,
  output logic        res_valid,
  output fpadd_resp_t res
);

  logic [2:0]  lead_lane;
  logic [5:0]  lead;
  logic [5:0]  lshift;
  logic        is_zero;
  logic        carry_out;
  logic        underflow;
  sig_t        norm_sig;
  exp_t        norm_exp;
  logic        lsb;
  logic        guard;
  logic        round_bit;
  logic        sticky;
  logic        dropped;
  logic        inc;
  logic [53:0] mant_r;
  exp_t        exp_r;
  logic        overflow;
  logic        to_inf;
  fpadd_resp_t res_next;

  // highest lane holding a one
  always_comb begin
    lead_lane = 3'd0;
    for (int k = 0; k < 8; k++) begin
      if (lane_has[k]) begin
        lead_lane = 3'(k);
      end
    end
  end

  assign lead      = {lead_lane, lane_pos[3*lead_lane +: 3]};
  assign is_zero   = ~|lane_has;
  assign carry_out = sum.sig[56];

  // the hidden bit sits at bit 62 of the padded lane vector
  assign lshift    = 6'd62 - lead;
  assign underflow = ~carry_out && (exp_t'(lshift) >= sum.exp);

  always_comb begin
    if (carry_out) begin
      norm_sig = {1'b0, sum.sig[56:2], sum.sig[1] | sum.sig[0]};
      norm_exp = sum.exp + 12'd1;
    end else begin
      norm_sig = sum.sig << lshift;
      norm_exp = sum.exp - exp_t'(lshift);
    end
  end

  assign lsb       = norm_sig[3];
  assign guard     = norm_sig[2];
  assign round_bit = norm_sig[1];
  assign sticky    = norm_sig[0];
  assign dropped   = guard | round_bit | sticky;

  always_comb begin
    case (sum.rmode)
      RND_EVEN:  inc = guard & (round_bit | sticky | lsb);
      RND_PLUS:  inc = dropped & ~sum.sign;
      RND_MINUS: inc = dropped & sum.sign;
      default:   inc = 1'b0;
    endcase
  end

  // a carry out of the mantissa leaves the fraction all zero
  assign mant_r   = {1'b0, norm_sig[55:3]} + 54'(inc);
  assign exp_r    = norm_exp + exp_t'(mant_r[53]);
  assign overflow = exp_r >= 12'h7ff;

  always_comb begin
    case (sum.rmode)
      RND_EVEN:  to_inf = 1'b1;
      RND_PLUS:  to_inf = ~sum.sign;
      RND_MINUS: to_inf = sum.sign;
      default:   to_inf = 1'b0;
    endcase
  end

  always_comb begin
    res_next.flags = '0;
    if (sum.spec_valid) begin
      res_next.result = sum.spec_value;
      res_next.flags  = sum.spec_flags;
    end else if (is_zero) begin
      res_next.result = {sum.sign, 63'd0};
    end else if (underflow) begin
      // flushed, no denormal results
      res_next.result = {sum.sign, 63'd0};
      res_next.flags[FLAG_INEXACT] = 1'b1;
    end else if (overflow) begin
      res_next.result = to_inf ? {sum.sign, 11'h7ff, 52'd0} : {sum.sign, 11'h7fe, {52{1'b1}}};
      res_next.flags[FLAG_OVERFLOW] = 1'b1;
      res_next.flags[FLAG_INEXACT]  = 1'b1;
    end else begin
      res_next.result = {sum.sign, exp_r[10:0], mant_r[51:0]};
      res_next.flags[FLAG_INEXACT] = dropped;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= sum_valid;
    end
  end

  always_ff @(posedge clk) begin
    res <= res_next;
  end

endmodule

//--- design/fpadd_result_queue.sv
`timescale 1ns/1ps

module fpadd_result_queue import fpadd_pkg::*; #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        res_valid,
  input  fpadd_resp_t res,
  output logic        in_credit,
  input  logic        out_credit,
  output logic        out_valid,
  output fpadd_resp_t out_resp
);

  localparam int PTR_W    = $clog2(QUEUE_DEPTH);
  localparam int CNT_W    = $clog2(QUEUE_DEPTH + 1);
  localparam int CREDIT_W = 16;

  fpadd_resp_t         mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CNT_W-1:0]    count;
  logic [CREDIT_W-1:0] credits;
  logic                push;
  logic                pop;

  // upstream credits keep writes from ever hitting a full queue
  assign push = res_valid;
  assign pop  = (credits != '0) && (count != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      credits   <= '0;
      out_valid <= 1'b0;
      in_credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count     <= count + CNT_W'(push) - CNT_W'(pop);
      credits   <= credits + CREDIT_W'(out_credit) - CREDIT_W'(pop);
      // each pop frees one slot upstream
      out_valid <= pop;
      in_credit <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= res;
    end
    if (pop) begin
      out_resp <= mem[rd_ptr];
    end
  end

endmodule

//--- design/fpadd_top.sv
`timescale 1ns/1ps

module fpadd_top import fpadd_pkg::*; #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        in_valid,
  input  fpadd_req_t  in_req,
  output logic        in_credit,
  output logic        out_valid,
  output fpadd_resp_t out_resp,
  input  logic        out_credit
);

  logic        al_valid;
  aligned_t    al;
  logic        sum_valid;
  sum_t        sum;
  logic [63:0] lzd_vec;
  logic [7:0]  lane_has;
  logic [23:0] lane_pos;
  logic        res_valid;
  fpadd_resp_t res;

  fpadd_align u_align (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_req   (in_req),
    .al_valid (al_valid),
    .al       (al)
  );

  fpadd_significand_add u_sig_add (
    .clk       (clk),
    .rst       (rst),
    .al_valid  (al_valid),
    .al        (al),
    .sum_valid (sum_valid),
    .sum       (sum)
  );

  // sum padded on the right to eight whole bytes
  assign lzd_vec = {sum.sig, 7'd0};

  for (genvar k = 0; k < 8; k++) begin : g_lane
    fpadd_lzd_lane u_lane (
      .byte_in  (lzd_vec[8*k +: 8]),
      .has_one  (lane_has[k]),
      .lead_pos (lane_pos[3*k +: 3])
    );
  end

  fpadd_normalize_round u_norm (
    .clk       (clk),
    .rst       (rst),
    .sum_valid (sum_valid),
    .sum       (sum),
    .lane_has  (lane_has),
    .lane_pos  (lane_pos),
    .res_valid (res_valid),
    .res       (res)
  );

  fpadd_result_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_queue (
    .clk        (clk),
    .rst        (rst),
    .res_valid  (res_valid),
    .res        (res),
    .in_credit  (in_credit),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_resp   (out_resp)
  );

endmodule

//--- verification/fpadd_queue_asserts.sv
`timescale 1ns/1ps

module fpadd_queue_asserts #(
  parameter int QUEUE_DEPTH = 4
) (
  input logic                               clk,
  input logic                               rst,
  input logic                               res_valid,
  input logic                               out_valid,
  input logic                               in_credit,
  input logic                               out_credit,
  input logic [$clog2(QUEUE_DEPTH + 1)-1:0] count
);

  logic [15:0] granted;
  // set when any assertion below fails
  logic        assert_failed = 1'b0;

  // consumer credits seen on the ports, less the results already sent
  always_ff @(posedge clk) begin
    if (rst) begin
      granted <= '0;
    end else begin
      granted <= granted + 16'(out_credit) - 16'(out_valid);
    end
  end

  // upstream credits must keep the queue from overflowing
  no_write_when_full: assert property (
    @(posedge clk) disable iff (rst) res_valid |-> (count < QUEUE_DEPTH)
  ) else begin
    $error("result written into a full queue");
    assert_failed = 1'b1;
  end

  valid_needs_credit: assert property (
    @(posedge clk) disable iff (rst) out_valid |-> (granted != '0)
  ) else begin
    $error("out_valid without an output credit");
    assert_failed = 1'b1;
  end

  credit_matches_valid: assert property (
    @(posedge clk) disable iff (rst) in_credit == out_valid
  ) else begin
    $error("in_credit differs from out_valid");
    assert_failed = 1'b1;
  end

  quiet_in_reset: assert property (
    @(posedge clk) rst |=> !out_valid
  ) else begin
    $error("out_valid high after a reset cycle");
    assert_failed = 1'b1;
  end

endmodule

bind fpadd_result_queue fpadd_queue_asserts #(
  .QUEUE_DEPTH (QUEUE_DEPTH)
) u_queue_asserts (
  .clk        (clk),
  .rst        (rst),
  .res_valid  (res_valid),
  .out_valid  (out_valid),
  .in_credit  (in_credit),
  .out_credit (out_credit),
  .count      (count)
);

//--- verification/fpadd_tb.sv
`timescale 1ns/1ps

module fpadd_tb import fpadd_pkg::*; ();

  localparam int QUEUE_DEPTH = 4;
  localparam int WAIT_LIMIT  = 200;
  localparam fp64_t ONE      = 64'h3ff0000000000000;
  localparam fp64_t PINF     = 64'h7ff0000000000000;
  localparam fp64_t NINF     = 64'hfff0000000000000;
  localparam fp64_t MAXF     = 64'h7fefffffffffffff;

  logic        clk;
  logic        rst;
  logic        in_valid;
  fpadd_req_t  in_req;
  logic        in_credit;
  logic        out_valid;
  fpadd_resp_t out_resp;
  logic        out_credit;

  logic [31:0] lcg_state = 32'hf15d;
  int          up_credits;
  int          received;
  logic        auto_grant;
  fpadd_resp_t expected_q[$];
  fpadd_resp_t exp_resp;

  fpadd_top #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) uut (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_req     (in_req),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_resp   (out_resp),
    .out_credit (out_credit)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [51:0] rand_frac();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi[31:12], lo};
  endfunction

  // bit-level model, three extra bits below the lsb for guard, round, sticky
  function automatic fpadd_resp_t ref_add(input fpadd_req_t req);
    logic        sa;
    logic        sb;
    logic        sbig;
    logic        eff_sub;
    logic        a_nan;
    logic        b_nan;
    logic        a_inf;
    logic        b_inf;
    logic [62:0] ma;
    logic [62:0] mb;
    logic [62:0] mbig;
    logic [62:0] msmall;
    logic [63:0] bsig;
    logic [63:0] ssig;
    logic [63:0] acc;
    logic [53:0] mant;
    logic        grs;
    logic        up;
    logic        to_inf;
    int          diff;
    int          e;
    fpadd_resp_t r;
    r = '0;
    sa = req.a[63];
    sb = req.b[63] ^ req.sub;
    eff_sub = sa ^ sb;
    a_inf = (req.a[62:52] == 11'h7ff) && (req.a[51:0] == 0);
    b_inf = (req.b[62:52] == 11'h7ff) && (req.b[51:0] == 0);
    a_nan = (req.a[62:52] == 11'h7ff) && (req.a[51:0] != 0);
    b_nan = (req.b[62:52] == 11'h7ff) && (req.b[51:0] != 0);
    if (a_nan || b_nan) begin
      r.result = QNAN_CANON;
      return r;
    end
    if (a_inf && b_inf && eff_sub) begin
      r.result = QNAN_CANON;
      r.flags[FLAG_INVALID] = 1'b1;
      return r;
    end
    if (a_inf || b_inf) begin
      r.result = {a_inf ? sa : sb, 11'h7ff, 52'd0};
      return r;
    end
    // zero exponent means zero, denormals included
    ma = (req.a[62:52] == 0) ? 63'd0 : req.a[62:0];
    mb = (req.b[62:52] == 0) ? 63'd0 : req.b[62:0];
    mbig   = (ma >= mb) ? ma : mb;
    msmall = (ma >= mb) ? mb : ma;
    sbig   = (ma >= mb) ? sa : sb;
    bsig = 64'(mbig[51:0]) << 3;
    ssig = 64'(msmall[51:0]) << 3;
    bsig[55] = mbig[62:52] != 0;
    ssig[55] = msmall[62:52] != 0;
    diff = int'(mbig[62:52]) - int'(msmall[62:52]);
    if (diff >= 60) begin
      ssig = 64'(ssig != 0);
    end else begin
      ssig = (ssig >> diff) | 64'((ssig & ((64'd1 << diff) - 1)) != 0);
    end
    acc = eff_sub ? bsig - ssig : bsig + ssig;
    if (acc == 0) begin
      r.result = {eff_sub ? (req.rmode == RND_MINUS) : sbig, 63'd0};
      return r;
    end
    e = int'(mbig[62:52]);
    if (acc[56]) begin
      acc = (acc >> 1) | (acc & 64'd1);
      e = e + 1;
    end else begin
      while (!acc[55]) begin
        acc = acc << 1;
        e = e - 1;
      end
    end
    if (e <= 0) begin
      r.result = {sbig, 63'd0};
      r.flags[FLAG_INEXACT] = 1'b1;
      return r;
    end
    grs = |acc[2:0];
    case (req.rmode)
      RND_EVEN:  up = acc[2] && (acc[1] || acc[0] || acc[3]);
      RND_PLUS:  up = grs && !sbig;
      RND_MINUS: up = grs && sbig;
      default:   up = 1'b0;
    endcase
    mant = {1'b0, acc[55:3]} + 54'(up);
    if (mant[53]) begin
      mant = mant >> 1;
      e = e + 1;
    end
    if (e >= 2047) begin
      to_inf = (req.rmode == RND_EVEN) || (req.rmode == RND_PLUS && !sbig) ||
               (req.rmode == RND_MINUS && sbig);
      r.result = to_inf ? {sbig, 11'h7ff, 52'd0} : {sbig, 11'h7fe, {52{1'b1}}};
      r.flags[FLAG_OVERFLOW] = 1'b1;
      r.flags[FLAG_INEXACT]  = 1'b1;
      return r;
    end
    r.result = {sbig, 11'(e), mant[51:0]};
    r.flags[FLAG_INEXACT] = grs;
    return r;
  endfunction

  // credits held after the current edge
  function automatic int avail_credits();
    return up_credits + int'(in_credit) - int'(in_valid);
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      up_credits <= QUEUE_DEPTH;
    end else begin
      assert (!in_valid || up_credits > 0) else begin
        report_failure("request sent without an input credit");
      end
      assert (avail_credits() <= QUEUE_DEPTH) else begin
        report_failure("more input credits returned than were spent");
      end
      up_credits <= avail_credits();
    end
  end

  // failures from the bound queue checker
  always @(posedge clk) begin
    assert (!uut.u_queue.u_queue_asserts.assert_failed) else begin
      report_failure("a result queue assertion failed");
    end
  end

  // compare process
  always @(posedge clk) begin
    if (!rst && out_valid) begin
      assert (expected_q.size() > 0) else begin
        report_failure("out_valid seen with no request outstanding");
      end
      exp_resp = expected_q.pop_front();
      assert (out_resp.result == exp_resp.result) else begin
        $display("Error: time %0t out_resp.result got %h expected %h",
                 $time, out_resp.result, exp_resp.result);
        report_failure("result mismatch");
      end
      assert (out_resp.flags == exp_resp.flags) else begin
        $display("Error: time %0t out_resp.flags got %b expected %b",
                 $time, out_resp.flags, exp_resp.flags);
        report_failure("flags mismatch");
      end
      received <= received + 1;
    end
  end

  task automatic send_pair(input fp64_t a, input fp64_t b, input logic sub,
                           input rnd_mode_t mode);
    fpadd_req_t req;
    int         waited;
    req = '{a: a, b: b, sub: sub, rmode: mode};
    waited = 0;
    @(posedge clk);
    while (avail_credits() <= 0) begin
      in_valid   <= 1'b0;
      out_credit <= 1'b0;
      if (waited >= WAIT_LIMIT) begin
        report_failure("timed out waiting for an input credit");
      end else begin
        waited++;
        @(posedge clk);
      end
    end
    in_valid   <= 1'b1;
    in_req     <= req;
    out_credit <= auto_grant;
    expected_q.push_back(ref_add(req));
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(posedge clk);
    in_valid   <= 1'b0;
    out_credit <= 1'b0;
    while (expected_q.size() != 0) begin
      if (waited >= WAIT_LIMIT) begin
        report_failure("timed out waiting for results to drain");
      end else begin
        waited++;
        @(posedge clk);
      end
    end
  endtask

  initial begin
    logic [31:0] r;
    fp64_t       a;
    fp64_t       b;
    int          start;
    int          waited;
    rst        = 1'b1;
    in_valid   = 1'b0;
    in_req     = '0;
    out_credit = 1'b0;
    auto_grant = 1'b1;
    received   = 0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // random normals with nearby exponents, all modes
    for (int i = 0; i < 300; i++) begin
      r = next_rand();
      a = {r[0], 11'h3f8 + 11'(r[4:1]), rand_frac()};
      b = {r[5], 11'h3f8 + 11'(r[9:6]), rand_frac()};
      send_pair(a, b, r[10], rnd_mode_t'(i % 4));
    end
    wait_drain();

    // specials and signed zeros
    for (int m = 0; m < 4; m++) begin
      send_pair(64'h7ff0000000000001, ONE, 1'b0, rnd_mode_t'(m));
      send_pair(ONE, 64'hfff8000000000123, 1'b1, rnd_mode_t'(m));
      send_pair(PINF, PINF, 1'b1, rnd_mode_t'(m));
      send_pair(PINF, NINF, 1'b0, rnd_mode_t'(m));
      send_pair(NINF, ONE, 1'b0, rnd_mode_t'(m));
      send_pair(ONE, PINF, 1'b1, rnd_mode_t'(m));
      send_pair(ONE, ONE, 1'b1, rnd_mode_t'(m));
      send_pair(64'd0, 64'h8000000000000000, 1'b0, rnd_mode_t'(m));
      send_pair(64'h8000000000000000, 64'h8000000000000000, 1'b0, rnd_mode_t'(m));
      send_pair(64'h000fffffffffffff, 64'd0, 1'b0, rnd_mode_t'(m));
    end
    wait_drain();

    // overflow and flush to zero
    for (int m = 0; m < 4; m++) begin
      send_pair(MAXF, MAXF, 1'b0, rnd_mode_t'(m));
      send_pair({1'b1, MAXF[62:0]}, {1'b1, MAXF[62:0]}, 1'b0, rnd_mode_t'(m));
      send_pair(MAXF, {1'b1, MAXF[62:0]}, 1'b1, rnd_mode_t'(m));
      send_pair({1'b0, 11'd2, 52'd1}, {1'b0, 11'd2, 52'd0}, 1'b1, rnd_mode_t'(m));
      send_pair({1'b1, 11'd1, 52'd5}, {1'b1, 11'd1, 52'd3}, 1'b1, rnd_mode_t'(m));
      send_pair({1'b0, 11'd1, 52'd3}, {1'b1, 11'd1, 52'd2}, 1'b0, rnd_mode_t'(m));
    end
    wait_drain();

    // exponent differences across every lane and the sticky-only range
    for (int d = 0; d <= 60; d++) begin
      for (int k = 0; k < 2; k++) begin
        r = next_rand();
        a = {r[0], 11'h400, rand_frac()};
        b = {r[1], 11'h400 - 11'(d), rand_frac()};
        if (d % 2 == 1) begin
          send_pair(b, a, k[0], rnd_mode_t'((d + k) % 4));
        end else begin
          send_pair(a, b, k[0], rnd_mode_t'((d + k) % 4));
        end
      end
    end
    wait_drain();

    // back-pressure, output credits withheld
    auto_grant = 1'b0;
    start = received;
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      r = next_rand();
      send_pair({1'b0, 11'h400, rand_frac()}, {r[0], 11'h3fe, rand_frac()}, r[1],
                rnd_mode_t'(r[3:2]));
    end
    for (int c = 0; c < 20; c++) begin
      @(posedge clk);
      in_valid <= 1'b0;
      assert (!out_valid && !in_credit) else begin
        report_failure("output or credit seen while output credits were withheld");
      end
      assert (avail_credits() == 0) else begin
        report_failure("upstream still holds credits with the queue full");
      end
    end
    for (int c = 0; c < QUEUE_DEPTH; c++) begin
      @(posedge clk);
      out_credit <= 1'b1;
    end
    @(posedge clk);
    out_credit <= 1'b0;
    waited = 0;
    while (received != start + QUEUE_DEPTH) begin
      if (waited >= WAIT_LIMIT) begin
        report_failure("timed out waiting for the queue to drain after credits");
      end else begin
        waited++;
        @(posedge clk);
      end
    end
    repeat (10) @(posedge clk);
    assert (received == start + QUEUE_DEPTH && expected_q.size() == 0) else begin
      report_failure("queue did not drain exactly its depth of results");
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- sources.f
design/fpadd_pkg.sv
design/fpadd_lzd_lane.sv
design/fpadd_align.sv
design/fpadd_significand_add.sv
design/fpadd_normalize_round.sv
design/fpadd_result_queue.sv
design/fpadd_top.sv
verification/fpadd_queue_asserts.sv
verification/fpadd_tb.sv
